/* Makefile */
VERILATOR ?= verilator
TOP       ?= pipeline_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/pipeline_stim.txt */
// Program image in words 00 to 1f, one instruction per word, zero is a no-op
// Retire count in word 20, then register and data pairs from word 21 on
@00
3C011234 34218765 2002FFFB 20030007
0043202A 0062282A 00433022 00223824
00664025 20600064 00034820 FC000000
200A0001 014A5020 014A5020 014A5020
014A5020 014A5020 014A5020 014A5020
014A5020 014A5020 01415822
@20
15
@21
01 12340000  01 12348765
02 FFFFFFFB  03 00000007
04 00000001  05 00000000
06 FFFFFFF4  07 12348761
08 FFFFFFF7  09 00000007
0a 00000001  0a 00000002
0a 00000004  0a 00000008
0a 00000010  0a 00000020
0a 00000040  0a 00000080
0a 00000100  0a 00000200
0b EDCB7A9B

/* dv/pipeline_tb.sv */
`timescale 1ns/1ns
`include "pip_config.svh"

module pipeline_tb;

  localparam int IMG_WORDS    = 32;
  localparam int STIM_WORDS   = 128;
  localparam int CNT_ADDR     = 32;
  localparam int EXP_ADDR     = 33;
  localparam int STALL_FROM   = 40;
  localparam int STALL_LEN    = 24;
  localparam int DRAIN_CYCLES = 100;

  logic                 clock;
  logic                 arst_n;
  logic [`PIP_XLEN-1:0] icache_addr;
  logic                 icache_rd;
  logic [`PIP_XLEN-1:0] icache_data;
  logic                 icache_waitrequest;
  pip_types::retire_t   retire;

  logic [31:0]          stim [STIM_WORDS];
  logic [31:0]          lfsr;
  logic [`PIP_XLEN-1:0] next_addr;
  int                   cycle;
  int                   prog_len;
  int                   exp_count;
  int                   retired;
  int                   value_errors;
  int                   other_errors;
  int                   limit_cycles;

  pipeline pipeline_inst (
    .clock              (clock),
    .arst_n             (arst_n),
    .icache_addr        (icache_addr),
    .icache_rd          (icache_rd),
    .icache_data        (icache_data),
    .icache_waitrequest (icache_waitrequest),
    .retire             (retire)
  );

  always #5 clock = ~clock;

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h8020_0003;
    end
    return next;
  endfunction

  task automatic take_lfsr_bit(output logic bit_out);
    bit_out = lfsr[0];
    lfsr    = lfsr_step(lfsr);
  endtask

  // Addresses past the image read as zero
  function automatic logic [31:0] image_word(input logic [`PIP_XLEN-1:0] addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < IMG_WORDS) begin
      return stim[idx];
    end
    return '0;
  endfunction

  task automatic check_idle_outputs();
    if (retire.valid !== 1'b0) begin
      $display("ERR %0t retire.valid expected 0 got %b", $time, retire.valid);
      value_errors++;
    end
    if (icache_rd !== 1'b0) begin
      $display("ERR %0t icache_rd expected 0 got %b", $time, icache_rd);
      value_errors++;
    end
  endtask

  task automatic check_retire();
    pip_types::reg_idx_t exp_reg;
    logic [31:0]         exp_data;
    if (retired >= exp_count) begin
      $display("%0t: extra retire beyond the expected %0d, r%0d = %h",
               $time, exp_count, retire.dest, retire.data);
      other_errors++;
    end else begin
      exp_reg  = pip_types::reg_idx_t'(stim[EXP_ADDR + 2 * retired]);
      exp_data = stim[EXP_ADDR + 2 * retired + 1];
      if (retire.dest !== exp_reg) begin
        $display("ERR %0t retire.dest expected %0d got %0d", $time, exp_reg, retire.dest);
        value_errors++;
      end
      if (retire.data !== exp_data) begin
        $display("ERR %0t retire.data expected %h got %h", $time, exp_data, retire.data);
        value_errors++;
      end
    end
    retired++;
  endtask

  task automatic finish_run(input logic timed_out);
    $display("Error counts: value %0d, other %0d, retires %0d of %0d",
             value_errors, other_errors, retired, exp_count);
    if (timed_out || value_errors != 0 || other_errors != 0 || retired != exp_count) begin
      $display("Done: errors found");
    end else begin
      $display("Done: no errors");
    end
    $finish;
  endtask

  // Cache model with random waitrequest plus one long forced stretch
  always @(negedge clock) begin : cache_model
    logic wait_bit;
    take_lfsr_bit(wait_bit);
    cycle = cycle + 1;
    icache_waitrequest = wait_bit | ((cycle >= STALL_FROM) && (cycle < STALL_FROM + STALL_LEN));
    if (!icache_waitrequest) begin
      icache_data = image_word(icache_addr);
      // Read gets accepted on the coming rising edge
      if (icache_rd) begin
        if (icache_addr !== next_addr) begin
          $display("ERR %0t icache_addr expected %h got %h", $time, next_addr, icache_addr);
          value_errors++;
        end
        next_addr = next_addr + 4;
      end
    end
  end

  always @(negedge clock) begin
    if (retire.valid === 1'b1) begin
      check_retire();
    end
  end

  initial begin
    clock              = 1'b0;
    arst_n             = 1'b0;
    icache_data        = '0;
    icache_waitrequest = 1'b0;
    lfsr               = 32'h5492_6110;
    next_addr          = `PIP_RESET_PC;
    cycle              = 0;
    retired            = 0;
    value_errors       = 0;
    other_errors       = 0;
    limit_cycles       = 0;
    for (int i = 0; i < STIM_WORDS; i++) begin
      stim[i] = '0;
    end
    $readmemh("dv/pipeline_stim.txt", stim);
    exp_count = int'(stim[CNT_ADDR]);
    prog_len  = 0;
    for (int i = 0; i < IMG_WORDS; i++) begin
      if (stim[i] != '0) begin
        prog_len = i + 1;
      end
    end
    if (exp_count == 0) begin
      $display("Stimulus file holds no expected retires");
      other_errors++;
    end
    limit_cycles = (prog_len + 8) * 40;
    repeat (2) begin
      @(negedge clock);
      check_idle_outputs();
    end
    arst_n = 1'b1;
    // First cycle out of reset starts reading
    @(negedge clock);
    if (icache_rd !== 1'b1) begin
      $display("ERR %0t icache_rd expected 1 got %b", $time, icache_rd);
      value_errors++;
    end
    if (retire.valid !== 1'b0) begin
      $display("ERR %0t retire.valid expected 0 got %b", $time, retire.valid);
      value_errors++;
    end
    wait (retired >= exp_count);
    // Watch for stray retires while no-ops drain
    repeat (DRAIN_CYCLES) @(negedge clock);
    finish_run(1'b0);
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clock);
    $display("Timeout after %0d cycles with %0d of %0d retires seen",
             limit_cycles, retired, exp_count);
    finish_run(1'b1);
  end

endmodule

/* list.f */
+incdir+logic
logic/pip_types.sv
logic/rfile.sv
logic/ex_alu.sv
logic/rob.sv
logic/iss.sv
logic/id.sv
logic/ifetch.sv
logic/pipeline.sv
dv/pipeline_tb.sv

/* logic/ex_alu.sv */
`timescale 1ns/1ns
`include "pip_config.svh"

module ex_alu (
  input  logic                  clock,
  input  logic                  arst_n,
  input  pip_types::dec_inst_t  inst,
  input  logic [`PIP_XLEN-1:0]  a,
  input  logic [`PIP_XLEN-1:0]  b,
  output pip_types::ex_result_t result
);

  logic [`PIP_XLEN-1:0] alu_out;

  always_comb begin
    case (inst.alu_op)
      pip_types::ALU_ADD: alu_out = a + b;
      pip_types::ALU_SUB: alu_out = a - b;
      pip_types::ALU_AND: alu_out = a & b;
      pip_types::ALU_OR:  alu_out = a | b;
      pip_types::ALU_SLT: alu_out = {{(`PIP_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      // Immediate already sits in the upper half
      pip_types::ALU_LUI: alu_out = b;
      default:            alu_out = '0;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else begin
      result.valid <= inst.valid;
      result.slot  <= inst.slot;
      result.data  <= alu_out;
    end
  end

endmodule

/* logic/id.sv */
`timescale 1ns/1ns
`include "pip_config.svh"

module id (
  input  logic                  clock,
  input  logic                  arst_n,
  input  pip_types::fetch_t     fetch,
  output logic                  stall,
  output pip_types::rob_alloc_t rob_alloc,
  input  pip_types::rob_idx_t   rob_tail,
  input  logic                  rob_full,
  input  logic                  iss_busy,
  output pip_types::dec_inst_t  inst
);

  localparam logic [5:0] FN_ADD = 6'h20;
  localparam logic [5:0] FN_SUB = 6'h22;
  localparam logic [5:0] FN_AND = 6'h24;
  localparam logic [5:0] FN_OR  = 6'h25;
  localparam logic [5:0] FN_SLT = 6'h2a;

  pip_types::inst_u     word;
  pip_types::dec_inst_t dec;

  assign word = fetch.word;

  always_comb begin
    dec        = '0;
    dec.slot   = rob_tail;
    dec.alu_op = pip_types::ALU_NOP;
    case (word.r.opcode)
      pip_types::OP_RTYPE: begin
        dec.src_a = word.r.rs;
        dec.src_b = word.r.rt;
        dec.dest  = word.r.rd;
        case (word.r.funct)
          FN_ADD:  dec.alu_op = pip_types::ALU_ADD;
          FN_SUB:  dec.alu_op = pip_types::ALU_SUB;
          FN_AND:  dec.alu_op = pip_types::ALU_AND;
          FN_OR:   dec.alu_op = pip_types::ALU_OR;
          FN_SLT:  dec.alu_op = pip_types::ALU_SLT;
          default: dec.alu_op = pip_types::ALU_NOP;
        endcase
      end
      pip_types::OP_ADDI: begin
        dec.alu_op = pip_types::ALU_ADD;
        dec.src_a  = word.i.rs;
        dec.dest   = word.i.rt;
        dec.imm    = {{(`PIP_XLEN-16){word.i.imm[15]}}, word.i.imm};
      end
      pip_types::OP_ORI: begin
        dec.alu_op = pip_types::ALU_OR;
        dec.src_a  = word.i.rs;
        dec.dest   = word.i.rt;
        dec.imm    = {{(`PIP_XLEN-16){1'b0}}, word.i.imm};
      end
      pip_types::OP_LUI: begin
        dec.alu_op = pip_types::ALU_LUI;
        dec.dest   = word.i.rt;
        dec.imm    = {word.i.imm, 16'h0000};
      end
      default: dec.alu_op = pip_types::ALU_NOP;
    endcase
    dec.b_is_imm = word.r.opcode != pip_types::OP_RTYPE;
    // No-ops carry no sources so they never wait on the ROB
    if (dec.alu_op == pip_types::ALU_NOP) begin
      dec.src_a = '0;
      dec.src_b = '0;
    end
    dec.dest_valid = (dec.alu_op != pip_types::ALU_NOP) && (dec.dest != '0);
  end

  assign stall                = iss_busy | rob_full;
  assign rob_alloc.reserve    = fetch.valid & ~stall;
  assign rob_alloc.dest       = dec.dest;
  assign rob_alloc.dest_valid = dec.dest_valid;

  // Issue takes this register whenever it is not busy
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      inst <= '0;
    end else if (!iss_busy) begin
      inst       <= dec;
      inst.valid <= fetch.valid & ~rob_full;
    end
  end

endmodule

/* logic/ifetch.sv */
`timescale 1ns/1ns
`include "pip_config.svh"

module ifetch (
  input  logic                 clock,
  input  logic                 arst_n,
  output logic [`PIP_XLEN-1:0] cache_addr,
  output logic                 cache_rd,
  input  logic [`PIP_XLEN-1:0] cache_data,
  input  logic                 cache_waitrequest,
  input  logic                 stall,
  output pip_types::fetch_t    fetch
);

  logic                 run;
  logic [`PIP_XLEN-1:0] pc;
  logic                 accept;

  // Reads start one cycle after reset release
  assign cache_rd   = run & ~stall;
  assign cache_addr = pc;
  assign accept     = cache_rd & ~cache_waitrequest;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      run   <= 1'b0;
      pc    <= `PIP_RESET_PC;
      fetch <= '0;
    end else begin
      run <= 1'b1;
      if (accept) begin
        pc <= pc + `PIP_XLEN'(4);
      end
      // Fetch register holds while decode is stalled
      if (!stall) begin
        fetch.valid <= accept;
        fetch.pc    <= pc;
        fetch.word  <= cache_data;
      end
    end
  end

endmodule

/* logic/iss.sv */
`timescale 1ns/1ns
`include "pip_config.svh"

module iss (
  input  logic                  clock,
  input  logic                  arst_n,
  input  pip_types::dec_inst_t  inst,
  output logic                  busy,
  output pip_types::as_query_t  as_query,
  input  pip_types::as_result_t as_result,
  output pip_types::reg_idx_t   rd_addr_a,
  output pip_types::reg_idx_t   rd_addr_b,
  input  logic [`PIP_XLEN-1:0]  rd_data_a,
  input  logic [`PIP_XLEN-1:0]  rd_data_b,
  output pip_types::dec_inst_t  ex_inst,
  output logic [`PIP_XLEN-1:0]  ex_a,
  output logic [`PIP_XLEN-1:0]  ex_b
);

  pip_types::dec_inst_t held;
  logic                 a_ready;
  logic                 b_ready;
  logic                 ready;

  // Search the ROB for producers older than this instruction
  assign as_query.slot = held.slot;
  assign as_query.areg = held.src_a;
  assign as_query.breg = held.src_b;

  assign rd_addr_a = held.src_a;
  assign rd_addr_b = held.src_b;

  // ROB value wins over the register file when an older writer exists
  assign a_ready = ~as_result.a.present | as_result.a.valid;
  assign b_ready = held.b_is_imm | ~as_result.b.present | as_result.b.valid;
  assign ready   = a_ready & b_ready;
  assign busy    = held.valid & ~ready;

  assign ex_a = as_result.a.present ? as_result.a.data : rd_data_a;

  always_comb begin
    if (held.b_is_imm) begin
      ex_b = held.imm;
    end else if (as_result.b.present) begin
      ex_b = as_result.b.data;
    end else begin
      ex_b = rd_data_b;
    end
  end

  always_comb begin
    ex_inst       = held;
    ex_inst.valid = held.valid & ready;
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      held <= '0;
    end else if (!busy) begin
      held <= inst;
    end
  end

endmodule

/* logic/pip_config.svh */
`ifndef PIP_CONFIG_SVH
`define PIP_CONFIG_SVH

// Data path and address width
`define PIP_XLEN 32

// Architectural registers with r0 reading as zero
`define PIP_NREGS 32

// Reorder buffer depth as a power of two
`define PIP_ROB_DEPTH 8

// First fetch address after reset
`define PIP_RESET_PC 32'h0000_0000

`endif

/* logic/pip_types.sv */
`include "pip_config.svh"

package pip_types;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'd0,
    OP_ADDI  = 6'd8,
    OP_ORI   = 6'd13,
    OP_LUI   = 6'd15
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI,
    ALU_NOP
  } alu_op_t;

  typedef logic [$clog2(`PIP_NREGS)-1:0] reg_idx_t;
  typedef logic [$clog2(`PIP_ROB_DEPTH)-1:0] rob_idx_t;

  // MIPS field layouts
  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [5:0]  funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_u;

  typedef struct packed {
    logic                 valid;
    logic [`PIP_XLEN-1:0] pc;
    inst_u                word;
  } fetch_t;

  typedef struct packed {
    logic                 valid;
    alu_op_t              alu_op;
    reg_idx_t             src_a;
    reg_idx_t             src_b;
    logic                 b_is_imm;
    logic [`PIP_XLEN-1:0] imm;
    reg_idx_t             dest;
    logic                 dest_valid;
    rob_idx_t             slot;
  } dec_inst_t;

  typedef struct packed {
    logic     reserve;
    reg_idx_t dest;
    logic     dest_valid;
  } rob_alloc_t;

  typedef struct packed {
    rob_idx_t slot;
    reg_idx_t areg;
    reg_idx_t breg;
  } as_query_t;

  // Present marks an older writer of the register and valid marks its result done
  typedef struct packed {
    logic                 present;
    logic                 valid;
    logic [`PIP_XLEN-1:0] data;
  } as_operand_t;

  typedef struct packed {
    as_operand_t a;
    as_operand_t b;
  } as_result_t;

  typedef struct packed {
    logic                 valid;
    rob_idx_t             slot;
    logic [`PIP_XLEN-1:0] data;
  } ex_result_t;

  typedef struct packed {
    logic                 valid;
    reg_idx_t             dest;
    logic [`PIP_XLEN-1:0] data;
  } retire_t;

endpackage

/* logic/pipeline.sv */
`timescale 1ns/1ns
`include "pip_config.svh"

module pipeline (
  input  logic                 clock,
  input  logic                 arst_n,
  output logic [`PIP_XLEN-1:0] icache_addr,
  output logic                 icache_rd,
  input  logic [`PIP_XLEN-1:0] icache_data,
  input  logic                 icache_waitrequest,
  output pip_types::retire_t   retire
);

  pip_types::fetch_t     fetch;
  logic                  id_stall;
  pip_types::rob_alloc_t rob_alloc;
  pip_types::rob_idx_t   rob_tail;
  logic                  rob_full;
  logic                  iss_busy;
  pip_types::dec_inst_t  id_inst;
  pip_types::as_query_t  as_query;
  pip_types::as_result_t as_result;
  pip_types::reg_idx_t   rd_addr_a;
  pip_types::reg_idx_t   rd_addr_b;
  logic [`PIP_XLEN-1:0]  rd_data_a;
  logic [`PIP_XLEN-1:0]  rd_data_b;
  pip_types::dec_inst_t  ex_inst;
  logic [`PIP_XLEN-1:0]  ex_a;
  logic [`PIP_XLEN-1:0]  ex_b;
  pip_types::ex_result_t ex_result;

  ifetch ifetch_inst (
    .clock             (clock),
    .arst_n            (arst_n),
    .cache_addr        (icache_addr),
    .cache_rd          (icache_rd),
    .cache_data        (icache_data),
    .cache_waitrequest (icache_waitrequest),
    .stall             (id_stall),
    .fetch             (fetch)
  );

  id id_inst_u (
    .clock     (clock),
    .arst_n    (arst_n),
    .fetch     (fetch),
    .stall     (id_stall),
    .rob_alloc (rob_alloc),
    .rob_tail  (rob_tail),
    .rob_full  (rob_full),
    .iss_busy  (iss_busy),
    .inst      (id_inst)
  );

  iss iss_inst (
    .clock     (clock),
    .arst_n    (arst_n),
    .inst      (id_inst),
    .busy      (iss_busy),
    .as_query  (as_query),
    .as_result (as_result),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .ex_inst   (ex_inst),
    .ex_a      (ex_a),
    .ex_b      (ex_b)
  );

  ex_alu ex_alu_inst (
    .clock  (clock),
    .arst_n (arst_n),
    .inst   (ex_inst),
    .a      (ex_a),
    .b      (ex_b),
    .result (ex_result)
  );

  rob rob_inst (
    .clock     (clock),
    .arst_n    (arst_n),
    .alloc     (rob_alloc),
    .tail      (rob_tail),
    .full      (rob_full),
    .as_query  (as_query),
    .as_result (as_result),
    .result    (ex_result),
    .retire    (retire)
  );

  rfile rfile_inst (
    .clock     (clock),
    .arst_n    (arst_n),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr        (retire)
  );

endmodule

/* logic/rfile.sv */
`timescale 1ns/1ns
`include "pip_config.svh"

module rfile (
  input  logic                 clock,
  input  logic                 arst_n,
  input  pip_types::reg_idx_t  rd_addr_a,
  input  pip_types::reg_idx_t  rd_addr_b,
  output logic [`PIP_XLEN-1:0] rd_data_a,
  output logic [`PIP_XLEN-1:0] rd_data_b,
  input  pip_types::retire_t   wr
);

  logic [`PIP_XLEN-1:0] regs [`PIP_NREGS];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `PIP_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid) begin
      regs[wr.dest] <= wr.data;
    end
  end

  // r0 is hardwired to zero
  assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

/* logic/rob.sv */
`timescale 1ns/1ns
`include "pip_config.svh"

module rob (
  input  logic                  clock,
  input  logic                  arst_n,
  input  pip_types::rob_alloc_t alloc,
  output pip_types::rob_idx_t   tail,
  output logic                  full,
  input  pip_types::as_query_t  as_query,
  output pip_types::as_result_t as_result,
  input  pip_types::ex_result_t result,
  output pip_types::retire_t    retire
);

  localparam int DEPTH = `PIP_ROB_DEPTH;
  localparam int IW    = $clog2(DEPTH);

  typedef struct packed {
    pip_types::reg_idx_t  dest;
    logic                 dest_valid;
    logic [`PIP_XLEN-1:0] value;
  } entry_t;

  entry_t              mem [DEPTH];
  logic [DEPTH-1:0]    done;
  pip_types::rob_idx_t head;
  logic [IW:0]         count;
  logic                do_retire;

  assign full      = count == (IW+1)'(DEPTH);
  assign do_retire = (count != '0) && done[head];

  // Head retires once done and only register writers reach the register file
  assign retire.valid = do_retire & mem[head].dest_valid;
  assign retire.dest  = mem[head].dest;
  assign retire.data  = mem[head].value;

  // Youngest older writer wins as the walk goes from head toward the query slot
  always_comb begin
    pip_types::rob_idx_t idx;
    pip_types::rob_idx_t qoff;
    as_result = '0;
    qoff      = as_query.slot - head;
    for (int k = 0; k < DEPTH; k++) begin
      idx = head + IW'(k);
      if (k < int'(qoff) && mem[idx].dest_valid) begin
        if (mem[idx].dest == as_query.areg) begin
          as_result.a.present = 1'b1;
          as_result.a.valid   = done[idx];
          as_result.a.data    = mem[idx].value;
        end
        if (mem[idx].dest == as_query.breg) begin
          as_result.b.present = 1'b1;
          as_result.b.valid   = done[idx];
          as_result.b.data    = mem[idx].value;
        end
      end
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end else begin
      if (alloc.reserve) begin
        tail       <= tail + 1'b1;
        done[tail] <= 1'b0;
      end
      if (result.valid) begin
        done[result.slot] <= 1'b1;
      end
      if (do_retire) begin
        head <= head + 1'b1;
      end
      case ({alloc.reserve, do_retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (alloc.reserve) begin
      mem[tail].dest       <= alloc.dest;
      mem[tail].dest_valid <= alloc.dest_valid;
    end
    if (result.valid) begin
      mem[result.slot].value <= result.data;
    end
  end

endmodule
